/* Makefile */
# Verilator simulation of the loop filter testbench

VERILATOR ?= verilator
TOP       ?= mdll_lf_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

# build, run, and grep the log for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
+incdir+dv
hw/mdll_pkg.sv
hw/mdll_ctl_sync.sv
hw/mdll_dco_integrator.sv
hw/mdll_dac_integrator.sv
hw/mdll_dac_sdm.sv
hw/mdll_lf.sv
hw/mdll_lf_top.sv
dv/mdll_lf_tb.sv

/* dv/mdll_lf_tests.svh */
// ------------------------------
// directed tests
// ------------------------------

task automatic test_load();
	int dco_ld;
	int dac_ld;
	begin_test("load");
	dco_ld = rand_bits(N_DCO_TI);
	dac_ld = rand_bits(N_DAC_TI);
	@(posedge clk_lf);
	gain_bb      <= '0;                  // no steps, words must sit at the load value
	gain_bb_dac  <= '0;
	en_sdm       <= 1'b0;
	ld_value     <= dco_int_t'(dco_ld);
	ld_value_dac <= dac_int_t'(dac_ld);
	load         <= 1'b1;
	settle();
	@(posedge clk_lf);
	load <= 1'b0;
	settle();
	repeat (20) begin
		drive_cycle(lfsr_bit());
		if (int'(dco_ctl_fine) != dco_ld)
			report_value("dco_ctl_fine", dco_ld, int'(dco_ctl_fine));
		if (int'(dac_ctl) != dac_ld)
			report_value("dac_ctl", dac_ld, int'(dac_ctl));
	end
	end_test();
endtask

task automatic test_integrate();
	int g_dco;
	int g_dac;
	begin_test("integrate");
	g_dco = rand_bits(N_BB_GB);
	g_dac = rand_bits(N_BB_GDAC);
	if (g_dco == 0)
		g_dco = 1;
	if (g_dac == 0)
		g_dac = 1;
	@(posedge clk_lf);
	gain_bb      <= gain_dco_t'(g_dco);
	gain_bb_dac  <= gain_dac_t'(g_dac);
	sel_dac_loop <= 1'b1;                // dac word only integrates in dac loop mode
	en_hold      <= 1'b0;
	settle();
	repeat (200) drive_cycle(lfsr_bit());
	end_test();
endtask

// run one direction until both outputs sit on their rails, then stay there
task automatic run_to_rails(input logic up, input int dco_rail, input int dac_rail);
	int cnt;
	cnt = 0;
	while ((int'(dco_ctl_fine) != dco_rail || int'(dac_ctl) != dac_rail)
			&& cnt < RAIL_TIMEOUT) begin
		drive_cycle(up);
		cnt++;
	end
	if (int'(dco_ctl_fine) != dco_rail || int'(dac_ctl) != dac_rail) begin
		$display("timeout in %s: outputs did not reach %0d and %0d within %0d cycles",
			test_name, dco_rail, dac_rail, RAIL_TIMEOUT);
		timed_out = 1'b1;
	end
	repeat (20) begin
		drive_cycle(up);
		if (int'(dco_ctl_fine) != dco_rail)
			report_value("dco_ctl_fine on rail", dco_rail, int'(dco_ctl_fine));
		if (int'(dac_ctl) != dac_rail)
			report_value("dac_ctl on rail", dac_rail, int'(dac_ctl));
	end
endtask

task automatic test_saturate();
	begin_test("saturate");
	@(posedge clk_lf);
	gain_bb     <= '1;                   // largest step
	gain_bb_dac <= '1;
	settle();
	run_to_rails(1'b1, (1 << N_DCO_TI) - 1, (1 << N_DAC_TI) - 1);
	run_to_rails(1'b0, 0, 0);
	end_test();
endtask

task automatic test_freeze();
	int held;
	begin_test("freeze");
	@(posedge clk_lf);
	gain_bb             <= gain_dco_t'(3);
	gain_bb_dac         <= gain_dac_t'(3);
	freeze_lf_dco_track <= 1'b1;
	settle();
	held = exp_dco();
	repeat (100) begin
		drive_cycle(lfsr_bit());
		if (int'(dco_ctl_fine) != held)
			report_value("frozen dco_ctl_fine", held, int'(dco_ctl_fine));
	end
	@(posedge clk_lf);
	freeze_lf_dco_track <= 1'b0;
	freeze_lf_dac_track <= 1'b1;
	settle();
	held = exp_dac();
	repeat (100) begin
		drive_cycle(lfsr_bit());
		if (int'(dac_ctl) != held)
			report_value("frozen dac_ctl", held, int'(dac_ctl));
	end
	@(posedge clk_lf);
	freeze_lf_dac_track <= 1'b0;
	end_test();
endtask

task automatic test_dac_mode();
	int ld;
	int drop;
	begin_test("dac_mode");
	for (int k = 0; k < 2; k++) begin
		ld   = (k == 0) ? 1 + rand_bits(N_DCO_TI - 1) : 0;  // second pass starts at zero
		drop = (ld == 0) ? 0 : ld - 1;
		@(posedge clk_lf);
		sel_dac_loop <= 1'b0;
		en_hold      <= 1'b1;
		gain_bb      <= '0;                  // dco still until the mode is entered
		gain_bb_dac  <= gain_dac_t'(2);
		ld_value     <= dco_int_t'(ld);
		load         <= 1'b1;
		settle();
		@(posedge clk_lf);
		load <= 1'b0;
		settle();
		if (int'(dco_ctl_fine) != ld)
			report_value("dco_ctl_fine before mode", ld, int'(dco_ctl_fine));
		@(posedge clk_lf);
		sel_dac_loop <= 1'b1;
		settle();                            // sync plus the latch cycle
		if (int'(dco_ctl_fine) != drop)
			report_value("dco_ctl_fine after entry", drop, int'(dco_ctl_fine));
		@(posedge clk_lf);
		gain_bb <= gain_dco_t'(4);           // hold must block these steps
		repeat (50) begin
			drive_cycle(lfsr_bit());
			if (int'(dco_ctl_fine) != drop)
				report_value("held dco_ctl_fine", drop, int'(dco_ctl_fine));
		end
		@(posedge clk_lf);
		sel_dac_loop <= 1'b0;
		settle();
		repeat (20) begin
			drive_cycle(lfsr_bit());
			if (int'(dac_ctl) != int'(ld_value_dac))
				report_value("dac_ctl after mode exit", int'(ld_value_dac), int'(dac_ctl));
		end
	end
	end_test();
endtask

task automatic test_sdm();
	int k;
	int frac;
	int base;
	int ones;
	begin_test("sdm");
	k = 9 + 2 * rand_bits(3);                // odd count, fraction cannot land on zero
	@(posedge clk_lf);
	sel_dac_loop <= 1'b1;
	en_hold      <= 1'b0;
	gain_bb_dac  <= '0;
	ld_value_dac <= dac_int_t'(8 + rand_bits(5));
	load         <= 1'b1;
	settle();
	@(posedge clk_lf);
	load        <= 1'b0;
	gain_bb_dac <= gain_dac_t'(1);           // two fraction lsbs per step
	settle();
	repeat (k) drive_cycle(1'b1);
	@(posedge clk_lf);
	freeze_lf_dac_track <= 1'b1;
	settle();
	frac = m_dac % DAC_LSB;
	base = m_dac >> N_DAC_TF;
	if (frac == 0)
		report_fail("dac fraction is zero, nothing to dither");
	@(posedge clk_lf);
	en_sdm <= 1'b1;
	settle();
	ones = 0;
	repeat (64) begin                        // one full sdm period
		drive_cycle(lfsr_bit());
		if (int'(dac_ctl) != base && int'(dac_ctl) != base + 1)
			report_value("dac_ctl dither range", base, int'(dac_ctl));
		ones += int'(dac_ctl) - base;
	end
	if (ones != frac)
		report_value("dither ones over 64 cycles", frac, ones);
	@(posedge clk_lf);
	en_sdm              <= 1'b0;
	freeze_lf_dac_track <= 1'b0;
	end_test();
endtask

/* dv/mdll_lf_tb.sv */
`timescale 1ns/1ps

module mdll_lf_tb import mdll_pkg::*; ();

	localparam int SYNC_DEPTH = 2;
	localparam int DCO_LSB    = 1 << N_DCO_TF;                 // one dco integer step
	localparam int DAC_LSB    = 1 << N_DAC_TF;
	localparam int DCO_TOP    = ((1 << N_DCO_TI) - 1) << N_DCO_TF;  // max int, zero fraction
	localparam int DAC_TOP    = ((1 << N_DAC_TI) - 1) << N_DAC_TF;
	localparam int CFG_W      = 6 + N_BB_GB + N_BB_GDAC;
	localparam int RAIL_TIMEOUT = 400;

	logic      clk_lf;
	logic      resetn_sync_clk_lf;
	logic      bb_out_inc;
	logic      load;
	dco_int_t  ld_value;
	dac_int_t  ld_value_dac;
	logic      sel_dac_loop;
	logic      en_hold;
	logic      freeze_lf_dco_track;
	logic      freeze_lf_dac_track;
	gain_dco_t gain_bb;
	gain_dac_t gain_bb_dac;
	logic      en_sdm;
	dco_int_t  dco_ctl_fine;
	dac_int_t  dac_ctl;

	logic [31:0] lfsr_state = 32'hd00b_2b8c;
	string       test_name;
	int          n_errors = 0;
	int          n_checks = 0;
	int          n_tests = 0;
	int          n_failed = 0;
	int          errors_at_start;
	logic        timed_out = 1'b0;

	mdll_lf_top #(.SYNC_DEPTH(SYNC_DEPTH)) uut (
		.clk_lf, .resetn_sync_clk_lf, .bb_out_inc, .load, .ld_value, .ld_value_dac,
		.sel_dac_loop, .en_hold, .freeze_lf_dco_track, .freeze_lf_dac_track,
		.gain_bb, .gain_bb_dac, .en_sdm, .dco_ctl_fine, .dac_ctl
	);

	initial begin
		clk_lf = 1'b0;
		forever #5 clk_lf = ~clk_lf;
	end

	// ------------------------------
	// reference model
	// ------------------------------
	logic [SYNC_DEPTH-1:0][CFG_W-1:0] cfg_pipe;   // config as seen SYNC_DEPTH edges later
	logic [CFG_W-1:0] cfg_now;
	logic      e_load, e_sel, e_hold, e_frz_dco, e_frz_dac, e_sdm;
	gain_dco_t e_gain_dco;
	gain_dac_t e_gain_dac;
	logic      sel_prev;
	int        m_dco;       // track words in fraction lsbs
	int        m_dac;
	int        m_acc;       // sdm residue
	logic      m_dither;

	assign cfg_now = {gain_bb_dac, gain_bb, en_sdm, freeze_lf_dac_track,
		freeze_lf_dco_track, en_hold, sel_dac_loop, load};
	assign {e_gain_dac, e_gain_dco, e_sdm, e_frz_dac, e_frz_dco, e_hold, e_sel, e_load} =
		cfg_pipe[SYNC_DEPTH-1];

	// +/- 2**g, clipped to the rails, g 0 is no step
	function automatic int step_word(input int word, input logic up, input int g,
			input int top);
		int w;
		w = word;
		if (g != 0)
			w = up ? word + (1 << g) : word - (1 << g);
		if (w < 0)
			w = 0;
		if (w > top)
			w = top;
		return w;
	endfunction

	always @(posedge clk_lf or negedge resetn_sync_clk_lf) begin : ref_model
		int   nxt_dco;
		int   nxt_dac;
		int   acc_sum;
		logic latch_m;
		logic hold_m;
		logic restore_m;
		if (!resetn_sync_clk_lf) begin
			cfg_pipe <= '0;
			sel_prev <= 1'b0;
			m_dco    <= int'(ld_value) << N_DCO_TF;
			m_dac    <= int'(ld_value_dac) << N_DAC_TF;
			m_acc    <= 0;
			m_dither <= 1'b0;
		end else begin
			latch_m   = e_sel && !sel_prev;     // first cycle of dac loop mode
			hold_m    = e_sel && e_hold;
			restore_m = !e_sel && !sel_prev;    // mode fully off
			nxt_dco = e_load ? (int'(ld_value) << N_DCO_TF)
				: step_word(m_dco, bb_out_inc, int'(e_gain_dco), DCO_TOP);
			nxt_dac = e_load ? (int'(ld_value_dac) << N_DAC_TF)
				: step_word(m_dac, bb_out_inc, int'(e_gain_dac), DAC_TOP);
			if (e_frz_dco)
				m_dco <= m_dco;
			else if (latch_m)
				m_dco <= (nxt_dco >= DCO_LSB) ? nxt_dco - DCO_LSB : nxt_dco;
			else if (!hold_m)
				m_dco <= nxt_dco;
			if (!e_frz_dac)
				m_dac <= restore_m ? (int'(ld_value_dac) << N_DAC_TF) : nxt_dac;
			acc_sum  = m_acc + (m_dac % DAC_LSB);
			m_acc    <= e_sdm ? acc_sum % DAC_LSB : 0;
			m_dither <= e_sdm && (acc_sum >= DAC_LSB);  // carry out
			cfg_pipe <= {cfg_pipe[SYNC_DEPTH-2:0], cfg_now};
			sel_prev <= e_sel;
		end
	end

	function automatic int exp_dco();
		return m_dco >> N_DCO_TF;
	endfunction

	function automatic int exp_dac();
		int i;
		i = m_dac >> N_DAC_TF;
		return (i == (1 << N_DAC_TI) - 1) ? i : i + int'(m_dither);  // clips at full scale
	endfunction

	// ------------------------------
	// stimulus helpers
	// ------------------------------
	// galois lfsr, x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = b ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		return b;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(lfsr_bit());
		return v;
	endfunction

	task automatic report_value(input string what, input int expected, input int actual);
		$display("[ERROR] %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
		n_errors++;
	endtask

	task automatic report_fail(input string msg);
		$display("%s failed: %s", test_name, msg);
		n_errors++;
	endtask

	task automatic begin_test(input string name);
		test_name       = name;
		errors_at_start = n_errors;
	endtask

	task automatic end_test();
		int errs;
		errs = n_errors - errors_at_start;
		n_tests++;
		if (errs != 0)
			n_failed++;
		$display("test %s: %s, %0d errors", test_name, (errs == 0) ? "ok" : "bad", errs);
	endtask

	// one pd bit, outputs compared with the model at the falling edge
	task automatic drive_cycle(input logic bit_in);
		@(posedge clk_lf);
		bb_out_inc <= bit_in;
		@(negedge clk_lf);
		n_checks++;
		if (int'(dco_ctl_fine) != exp_dco())
			report_value("dco_ctl_fine vs model", exp_dco(), int'(dco_ctl_fine));
		if (int'(dac_ctl) != exp_dac())
			report_value("dac_ctl vs model", exp_dac(), int'(dac_ctl));
	endtask

	task automatic settle();
		repeat (SYNC_DEPTH + 2) drive_cycle(lfsr_bit());  // sync chain plus mode decode
	endtask

	`include "mdll_lf_tests.svh"

	// ------------------------------
	// sequence
	// ------------------------------
	initial begin
		resetn_sync_clk_lf  <= 1'b0;
		bb_out_inc          <= 1'b0;
		load                <= 1'b0;
		ld_value            <= dco_int_t'(100);
		ld_value_dac        <= dac_int_t'(20);
		sel_dac_loop        <= 1'b0;
		en_hold             <= 1'b0;
		freeze_lf_dco_track <= 1'b0;
		freeze_lf_dac_track <= 1'b0;
		gain_bb             <= '0;
		gain_bb_dac         <= '0;
		en_sdm              <= 1'b0;
		repeat (4) @(posedge clk_lf);
		resetn_sync_clk_lf <= 1'b1;
		if (!timed_out)
			test_load();
		if (!timed_out)
			test_integrate();
		if (!timed_out)
			test_saturate();
		if (!timed_out)
			test_freeze();
		if (!timed_out)
			test_dac_mode();
		if (!timed_out)
			test_sdm();
		$display("tests %0d, failed %0d, cycle checks %0d, errors %0d, timeout %0d",
			n_tests, n_failed, n_checks, n_errors, timed_out);
		if (timed_out || n_errors != 0) begin
			$display("=== FAIL ===");
		end else begin
			$display("=== PASS ===");
		end
		$finish;
	end

endmodule

/* hw/mdll_ctl_sync.sv */
`timescale 1ns/1ps

module mdll_ctl_sync import mdll_pkg::*; #(
	parameter int SYNC_DEPTH = 2       // flops per control bit
) (
	input  logic      clk_lf,
	input  logic      resetn_sync_clk_lf,
	input  logic      load,               // async, quasi-static
	input  logic      sel_dac_loop,       // 1: supply dac loop
	input  logic      en_hold,
	input  logic      freeze_lf_dco_track,
	input  logic      freeze_lf_dac_track,
	input  gain_dco_t gain_bb,
	input  gain_dac_t gain_bb_dac,
	input  logic      en_sdm,
	output logic      load_sync,
	output logic      freeze_dco_sync,
	output logic      freeze_dac_sync,
	output gain_dco_t gain_bb_sync,
	output gain_dac_t gain_bb_dac_sync,
	output logic      en_sdm_sync,
	output logic      latch_dco,          // one pulse on sel_dac_loop rise
	output logic      hold_dco,
	output logic      reset_dac
);

	localparam int N_CTL = 6 + N_BB_GB + N_BB_GDAC;  // single bits + both gain codes

	logic [N_CTL-1:0]                  ctl_async;
	logic [N_CTL-1:0]                  ctl_sync;
	logic [SYNC_DEPTH-1:0][N_CTL-1:0]  sync_q;      // [0] is the metastable stage
	logic                              sel_sync;
	logic                              sel_hist_q;  // extra stage behind sel_sync
	logic                              en_hold_sync;

	// ------------------------------
	// synchronizer chains
	// ------------------------------
	assign ctl_async = {load, en_hold, freeze_lf_dco_track, freeze_lf_dac_track,
		en_sdm, sel_dac_loop, gain_bb, gain_bb_dac};

	// every bit its own chain, gain codes included
	always_ff @(posedge clk_lf or negedge resetn_sync_clk_lf) begin
		if (!resetn_sync_clk_lf) begin
			sync_q     <= '0;
			sel_hist_q <= 1'b0;   // keeps latch_dco low out of reset
		end else begin
			sync_q[0] <= ctl_async;
			for (int i = 1; i < SYNC_DEPTH; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
			sel_hist_q <= sel_sync;
		end
	end

	assign ctl_sync = sync_q[SYNC_DEPTH-1];
	assign {load_sync, en_hold_sync, freeze_dco_sync, freeze_dac_sync,
		en_sdm_sync, sel_sync, gain_bb_sync, gain_bb_dac_sync} = ctl_sync;

	// ------------------------------
	// dac loop mode decode
	// ------------------------------
	assign latch_dco = sel_sync & ~sel_hist_q;                  // rising edge
	assign hold_dco  = sel_sync & sel_hist_q & en_hold_sync;    // dac loop running
	assign reset_dac = ~sel_sync & ~sel_hist_q;                 // nominal bb loop

	// decrement of the dco integer must happen once per mode entry
	a_latch_single: assert property (@(posedge clk_lf) disable iff (!resetn_sync_clk_lf)
		latch_dco |=> !latch_dco);

endmodule

/* hw/mdll_dac_integrator.sv */
`timescale 1ns/1ps

module mdll_dac_integrator import mdll_pkg::*; (
	input  logic       clk_lf,
	input  logic       resetn_sync_clk_lf,
	input  logic       step_up,      // bang-bang pd bit
	input  gain_dac_t  gain,         // 2**gain, 0 -> none
	input  logic       load,
	input  dac_int_t   ld_value,     // quasi-static
	input  logic       freeze,
	input  logic       restore,      // back to load value while not in dac mode
	output dac_track_t track
);

	dac_track_t track_ld;
	dac_track_t track_nxt;

	// ------------------------------
	// next word
	// ------------------------------
	assign track_ld  = {ld_value, {N_DAC_TF{1'b0}}};
	assign track_nxt = load ? track_ld : sat_step_dac(track, step_up, gain);

	// freeze > restore > step
	always_ff @(posedge clk_lf or negedge resetn_sync_clk_lf) begin
		if (!resetn_sync_clk_lf) begin
			track <= track_ld;
		end else if (freeze) begin
			track <= track;
		end else if (restore) begin
			track <= track_ld;           // nominal loop owns the dco, dac parked
		end else begin
			track <= track_nxt;
		end
	end

endmodule

/* hw/mdll_dac_sdm.sv */
`timescale 1ns/1ps

module mdll_dac_sdm import mdll_pkg::*; (
	input  logic      clk_lf,
	input  logic      resetn_sync_clk_lf,
	input  logic      en,          // synchronized en_sdm
	input  dac_frac_t frac,        // dac fraction to be dithered
	output logic      dither       // one-bit carry, registered
);

	dac_frac_t              acc_q;     // error term of the first-order loop
	logic [N_DAC_TF:0]      acc_sum;   // one extra bit for the carry

	// ------------------------------
	// error feedback accumulator
	// ------------------------------
	// carry density = frac / 2**N_DAC_TF
	assign acc_sum = {1'b0, acc_q} + {1'b0, frac};

	always_ff @(posedge clk_lf or negedge resetn_sync_clk_lf) begin
		if (!resetn_sync_clk_lf) begin
			acc_q  <= '0;
			dither <= 1'b0;
		end else if (!en) begin
			acc_q  <= '0;                       // restart from zero error
			dither <= 1'b0;
		end else begin
			acc_q  <= acc_sum[N_DAC_TF-1:0];    // keep the residue
			dither <= acc_sum[N_DAC_TF];        // overflow is the output bit
		end
	end

endmodule

/* hw/mdll_dco_integrator.sv */
`timescale 1ns/1ps

module mdll_dco_integrator import mdll_pkg::*; (
	input  logic       clk_lf,
	input  logic       resetn_sync_clk_lf,
	input  logic       step_up,      // bang-bang pd bit, 1: up
	input  gain_dco_t  gain,         // step = 2**gain lsbs, 0 -> none
	input  logic       load,         // synchronized load
	input  dco_int_t   ld_value,     // quasi-static
	input  logic       freeze,
	input  logic       latch_dec,    // single pulse from mode decode
	input  logic       hold,
	output dco_track_t track
);

	dco_track_t track_ld;     // load value, zero fraction
	dco_track_t track_nxt;    // stepped and clipped, or load
	dco_track_t track_dec;    // track_nxt with integer - 1
	dco_int_t   nxt_int;

	// ------------------------------
	// next word
	// ------------------------------
	assign track_ld  = {ld_value, {N_DCO_TF{1'b0}}};
	assign track_nxt = load ? track_ld : sat_step_dco(track, step_up, gain);

	assign nxt_int = track_nxt[N_DCO_T-1 -: N_DCO_TI];

	// decrement the integer only, fraction carried over
	// integer already at 0 -> no wrap, take track_nxt as is
	always_comb begin
		if (nxt_int != '0) begin
			track_dec = {dco_int_t'(nxt_int - 1'b1), track_nxt[N_DCO_TF-1:0]};
		end else begin
			track_dec = track_nxt;
		end
	end

	// ------------------------------
	// track register
	// ------------------------------
	// freeze > latch > hold > step
	always_ff @(posedge clk_lf or negedge resetn_sync_clk_lf) begin
		if (!resetn_sync_clk_lf) begin
			track <= track_ld;
		end else if (freeze) begin
			track <= track;              // loop opened
		end else if (latch_dec) begin
			track <= track_dec;          // entry into dac loop mode
		end else if (!hold) begin
			track <= track_nxt;
		end
	end

	// the decrement and the load path must not leave a fraction above the top
	a_top_frac_zero: assert property (@(posedge clk_lf) disable iff (!resetn_sync_clk_lf)
		(!freeze && !hold) |=>
		((track[N_DCO_T-1 -: N_DCO_TI] == '1) -> (track[N_DCO_TF-1:0] == '0)));

endmodule

/* hw/mdll_lf.sv */
`timescale 1ns/1ps

module mdll_lf import mdll_pkg::*; (
	input  logic      clk_lf,
	input  logic      resetn_sync_clk_lf,
	input  logic      bb_out_inc,         // pd bit, valid every cycle
	input  logic      load_sync,
	input  logic      freeze_dco_sync,
	input  logic      freeze_dac_sync,
	input  gain_dco_t gain_bb_sync,
	input  gain_dac_t gain_bb_dac_sync,
	input  logic      en_sdm_sync,
	input  logic      latch_dco,
	input  logic      hold_dco,
	input  logic      reset_dac,
	input  dco_int_t  ld_value,
	input  dac_int_t  ld_value_dac,
	output dco_int_t  dco_ctl_fine,
	output dac_int_t  dac_ctl
);

	dco_track_t dco_track;
	dac_track_t dac_track;
	dac_int_t   dac_int;
	dac_frac_t  dac_frac;
	logic       dac_dither;

	// ------------------------------
	// integrators
	// ------------------------------
	mdll_dco_integrator u_dco_int (
		.clk_lf             (clk_lf),
		.resetn_sync_clk_lf (resetn_sync_clk_lf),
		.step_up            (bb_out_inc),
		.gain               (gain_bb_sync),
		.load               (load_sync),
		.ld_value           (ld_value),
		.freeze             (freeze_dco_sync),
		.latch_dec          (latch_dco),
		.hold               (hold_dco),
		.track              (dco_track)
	);

	mdll_dac_integrator u_dac_int (
		.clk_lf             (clk_lf),
		.resetn_sync_clk_lf (resetn_sync_clk_lf),
		.step_up            (bb_out_inc),         // same pd bit drives both loops
		.gain               (gain_bb_dac_sync),
		.load               (load_sync),
		.ld_value           (ld_value_dac),
		.freeze             (freeze_dac_sync),
		.restore            (reset_dac),
		.track              (dac_track)
	);

	mdll_dac_sdm u_sdm (
		.clk_lf             (clk_lf),
		.resetn_sync_clk_lf (resetn_sync_clk_lf),
		.en                 (en_sdm_sync),
		.frac               (dac_frac),
		.dither             (dac_dither)
	);

	// ------------------------------
	// outputs
	// ------------------------------
	assign dco_ctl_fine = dco_track[N_DCO_T-1 -: N_DCO_TI];
	assign dac_int      = dac_track[N_DAC_T-1 -: N_DAC_TI];
	assign dac_frac     = dac_track[N_DAC_TF-1:0];

	// int + dither, clipped at full scale
	assign dac_ctl = (dac_int == '1) ? dac_int : dac_int + dac_int_t'(dac_dither);

endmodule

/* hw/mdll_lf_top.sv */
`timescale 1ns/1ps

module mdll_lf_top import mdll_pkg::*; #(
	parameter int SYNC_DEPTH = 2
) (
	input  logic      clk_lf,
	input  logic      resetn_sync_clk_lf,   // already synchronized to clk_lf
	input  logic      bb_out_inc,
	input  logic      load,
	input  dco_int_t  ld_value,
	input  dac_int_t  ld_value_dac,
	input  logic      sel_dac_loop,
	input  logic      en_hold,
	input  logic      freeze_lf_dco_track,
	input  logic      freeze_lf_dac_track,
	input  gain_dco_t gain_bb,
	input  gain_dac_t gain_bb_dac,
	input  logic      en_sdm,
	output dco_int_t  dco_ctl_fine,
	output dac_int_t  dac_ctl
);

	logic      load_sync;
	logic      freeze_dco_sync;
	logic      freeze_dac_sync;
	gain_dco_t gain_bb_sync;
	gain_dac_t gain_bb_dac_sync;
	logic      en_sdm_sync;
	logic      latch_dco;
	logic      hold_dco;
	logic      reset_dac;

	mdll_ctl_sync #(.SYNC_DEPTH(SYNC_DEPTH)) u_ctl_sync (
		.clk_lf, .resetn_sync_clk_lf,
		.load, .sel_dac_loop, .en_hold, .freeze_lf_dco_track, .freeze_lf_dac_track,
		.gain_bb, .gain_bb_dac, .en_sdm,
		.load_sync, .freeze_dco_sync, .freeze_dac_sync, .gain_bb_sync, .gain_bb_dac_sync,
		.en_sdm_sync, .latch_dco, .hold_dco, .reset_dac
	);

	// load values bypass the synchronizers, sampled only under load_sync
	mdll_lf u_lf (
		.clk_lf, .resetn_sync_clk_lf, .bb_out_inc,
		.load_sync, .freeze_dco_sync, .freeze_dac_sync, .gain_bb_sync, .gain_bb_dac_sync,
		.en_sdm_sync, .latch_dco, .hold_dco, .reset_dac,
		.ld_value, .ld_value_dac,
		.dco_ctl_fine, .dac_ctl
	);

endmodule

/* hw/mdll_pkg.sv */
package mdll_pkg;

	// ------------------------------
	// word widths
	// ------------------------------
	localparam int N_DCO_TI  = 8;                  // dco integer bits
	localparam int N_DCO_TF  = 6;                  // dco fraction bits
	localparam int N_DCO_T   = N_DCO_TI + N_DCO_TF;
	localparam int N_DAC_TI  = 6;                  // supply dac integer bits
	localparam int N_DAC_TF  = 6;                  // also the sdm accumulator width
	localparam int N_DAC_T   = N_DAC_TI + N_DAC_TF;
	localparam int N_BB_GB   = 3;
	localparam int N_BB_GDAC = 3;

	typedef logic [N_DCO_T-1:0]   dco_track_t;
	typedef logic [N_DCO_TI-1:0]  dco_int_t;
	typedef logic [N_DAC_T-1:0]   dac_track_t;
	typedef logic [N_DAC_TI-1:0]  dac_int_t;
	typedef logic [N_DAC_TF-1:0]  dac_frac_t;
	typedef logic [N_BB_GB-1:0]   gain_dco_t;
	typedef logic [N_BB_GDAC-1:0] gain_dac_t;

	// top of range: max integer, zero fraction
	localparam dco_track_t DCO_TRACK_MAX = {{N_DCO_TI{1'b1}}, {N_DCO_TF{1'b0}}};
	localparam dac_track_t DAC_TRACK_MAX = {{N_DAC_TI{1'b1}}, {N_DAC_TF{1'b0}}};

	// word +/- 2**g fraction lsbs, clipped to [0, max]
	function automatic dco_track_t sat_step_dco(input dco_track_t word, input logic up,
			input gain_dco_t g);
		logic signed [N_DCO_T+1:0] mag;  // two guard bits for over/underflow
		logic signed [N_DCO_T+1:0] sum;
		mag = (g == '0) ? '0 : ({{(N_DCO_T+1){1'b0}}, 1'b1} << g);  // gain 0 -> no step
		sum = $signed({2'b00, word}) + (up ? mag : -mag);
		if (sum < 0)
			return '0;
		else if (sum > $signed({2'b00, DCO_TRACK_MAX}))
			return DCO_TRACK_MAX;
		return sum[N_DCO_T-1:0];
	endfunction

	// same rule, supply dac word
	function automatic dac_track_t sat_step_dac(input dac_track_t word, input logic up,
			input gain_dac_t g);
		logic signed [N_DAC_T+1:0] mag;
		logic signed [N_DAC_T+1:0] sum;
		mag = (g == '0) ? '0 : ({{(N_DAC_T+1){1'b0}}, 1'b1} << g);
		sum = $signed({2'b00, word}) + (up ? mag : -mag);
		if (sum < 0)
			return '0;
		else if (sum > $signed({2'b00, DAC_TRACK_MAX}))
			return DAC_TRACK_MAX;
		return sum[N_DAC_T-1:0];
	endfunction

endpackage
